/* Bender.yml */
package:
  name: rvv_alu_shift

sources:
  - common/shift_pkg.sv
  - common/shift_ctrl_if.sv
  - verilog/shift_decode.sv
  - shift_lane/shift_lane.sv
  - shift_lane/shift_lane_bank.sv
  - verilog/shift_narrow.sv
  - verilog/rvv_alu_shift.sv
  - target: test
    files:
      - verification/tb_rvv_alu_shift.sv

/* common/shift_ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface shift_ctrl_if;

  logic                op_valid;
  logic [1:0]          shift_op;
  logic [1:0]          eew;
  logic [1:0]          vxrm;
  logic                scaling;
  logic                narrowing;
  logic                clipping;
  logic                clip_signed;
  shift_pkg::amount_u  amounts;
  logic                upper_half;

  modport decoder (
    output op_valid, shift_op, eew, vxrm, scaling, narrowing,
    output clipping, clip_signed, amounts, upper_half
  );

  modport datapath (
    input op_valid, shift_op, eew, vxrm, scaling, narrowing,
    input clipping, clip_signed, amounts, upper_half
  );

endinterface

`default_nettype wire

/* common/shift_pkg.sv */
`default_nettype none

package shift_pkg;

  // sizes
  localparam int vlen        = 128;
  localparam int vlenb       = vlen / 8;
  localparam int xlen        = 32;
  localparam int byte_w      = 8;
  localparam int hword_w     = 16;
  localparam int word_w      = 32;
  localparam int uop_index_w = 3;

  // operand forms
  localparam logic [2:0] opivv = 3'b000;
  localparam logic [2:0] opivx = 3'b100;
  localparam logic [2:0] opivi = 3'b011;

  // shift opcodes
  localparam logic [5:0] vsll    = 6'b100101;
  localparam logic [5:0] vsrl    = 6'b101000;
  localparam logic [5:0] vsra    = 6'b101001;
  localparam logic [5:0] vssrl   = 6'b101010;
  localparam logic [5:0] vssra   = 6'b101011;
  localparam logic [5:0] vnsrl   = 6'b101100;
  localparam logic [5:0] vnsra   = 6'b101101;
  localparam logic [5:0] vnclipu = 6'b101110;
  localparam logic [5:0] vnclip  = 6'b101111;

  // fixed-point rounding modes
  localparam logic [1:0] rnu = 2'b00;
  localparam logic [1:0] rne = 2'b01;
  localparam logic [1:0] rdn = 2'b10;
  localparam logic [1:0] rod = 2'b11;

  // element widths, 2'b11 is reserved
  localparam logic [1:0] eew8     = 2'b00;
  localparam logic [1:0] eew16    = 2'b01;
  localparam logic [1:0] eew32    = 2'b10;
  localparam logic [1:0] eew_rsvd = 2'b11;

  // shift kinds
  localparam logic [1:0] sll = 2'b00;
  localparam logic [1:0] srl = 2'b01;
  localparam logic [1:0] sra = 2'b10;

  // amount field widths per element width
  localparam int amt8_w   = $clog2(byte_w);
  localparam int amt16_w  = $clog2(hword_w);
  localparam int amt32_w  = $clog2(word_w);
  localparam int amount_w = vlenb * amt8_w;

  // one vector register, seen as byte, halfword or word lanes
  typedef union packed {
    logic [vlenb-1:0][byte_w-1:0]          b;
    logic [vlen/hword_w-1:0][hword_w-1:0]  h;
    logic [vlen/word_w-1:0][word_w-1:0]    w;
  } vreg_u;

  typedef struct packed {
    logic [amount_w-(vlen/hword_w)*amt16_w-1:0] pad;
    logic [vlen/hword_w-1:0][amt16_w-1:0]       a;
  } amount16_t;

  typedef struct packed {
    logic [amount_w-(vlen/word_w)*amt32_w-1:0] pad;
    logic [vlen/word_w-1:0][amt32_w-1:0]       a;
  } amount32_t;

  // per-lane shift amounts, narrow views padded at the top
  typedef union packed {
    logic [vlenb-1:0][amt8_w-1:0] a8;
    amount16_t                    a16;
    amount32_t                    a32;
  } amount_u;

endpackage

`default_nettype wire

/* rvv_alu_shift.f */
common/shift_pkg.sv
common/shift_ctrl_if.sv
verilog/shift_decode.sv
shift_lane/shift_lane.sv
shift_lane/shift_lane_bank.sv
verilog/shift_narrow.sv
verilog/rvv_alu_shift.sv
verification/tb_rvv_alu_shift.sv

/* shift_lane/shift_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module shift_lane #(
  parameter int width = 8
) (
  input  wire  [1:0]               shift_op,
  input  wire  [1:0]               vxrm,
  input  wire  [width-1:0]         operand,
  input  wire  [$clog2(width)-1:0] amount,
  output logic [width-1:0]         shifted,
  output logic [width-1:0]         rounded,
  output logic                     carry
);

  logic [2*width-1:0] ext;
  logic [2*width-1:0] res;
  logic [width-1:0]   round_bits;
  logic               incr;
  logic               sign_bit;

  // low half collects the bits shifted out
  assign ext = {operand, {width{1'b0}}};

  always_comb begin
    case (shift_op)
      shift_pkg::sll: res = ext << amount;
      shift_pkg::srl: res = ext >> amount;
      shift_pkg::sra: res = $signed(ext) >>> amount;
      default:        res = '0;
    endcase
  end

  assign shifted    = res[2*width-1:width];
  assign round_bits = res[width-1:0];

  always_comb begin
    case (vxrm)
      shift_pkg::rnu: incr = round_bits[width-1];
      shift_pkg::rne: incr = round_bits[width-1] &
                             ((|round_bits[width-2:0]) | shifted[0]);
      shift_pkg::rdn: incr = 1'b0;
      shift_pkg::rod: incr = !shifted[0] && (|round_bits);
      default:        incr = 1'b0;
    endcase
  end

  // extra top bit keeps the true value for the clip checks
  assign sign_bit = (shift_op == shift_pkg::sra) && shifted[width-1];
  assign {carry, rounded} = {sign_bit, shifted} + (width + 1)'(incr);

endmodule

`default_nettype wire

/* shift_lane/shift_lane_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module shift_lane_bank (
  input  wire shift_pkg::vreg_u                                         vs2_data,
  shift_ctrl_if.datapath                                                ctrl,
  output shift_pkg::vreg_u                                              wide_data,
  output logic [shift_pkg::vlen/shift_pkg::hword_w-1:0][shift_pkg::hword_w-1:0] shifted16,
  output logic [shift_pkg::vlen/shift_pkg::hword_w-1:0][shift_pkg::hword_w-1:0] rounded16,
  output logic [shift_pkg::vlen/shift_pkg::hword_w-1:0]                 carry16,
  output logic [shift_pkg::vlen/shift_pkg::word_w-1:0][shift_pkg::word_w-1:0]   shifted32,
  output logic [shift_pkg::vlen/shift_pkg::word_w-1:0][shift_pkg::word_w-1:0]   rounded32,
  output logic [shift_pkg::vlen/shift_pkg::word_w-1:0]                  carry32
);

  logic [shift_pkg::vlenb-1:0][shift_pkg::byte_w-1:0] shifted8;
  logic [shift_pkg::vlenb-1:0][shift_pkg::byte_w-1:0] rounded8;

  for (genvar i = 0; i < shift_pkg::vlenb; i++) begin : g_lane8
    shift_lane #(.width(shift_pkg::byte_w)) i_shift_lane (
      .shift_op (ctrl.shift_op),
      .vxrm     (ctrl.vxrm),
      .operand  (vs2_data.b[i]),
      .amount   (ctrl.amounts.a8[i]),
      .shifted  (shifted8[i]),
      .rounded  (rounded8[i]),
      .carry    ()
    );
  end

  for (genvar i = 0; i < shift_pkg::vlen / shift_pkg::hword_w; i++) begin : g_lane16
    shift_lane #(.width(shift_pkg::hword_w)) i_shift_lane (
      .shift_op (ctrl.shift_op),
      .vxrm     (ctrl.vxrm),
      .operand  (vs2_data.h[i]),
      .amount   (ctrl.amounts.a16.a[i]),
      .shifted  (shifted16[i]),
      .rounded  (rounded16[i]),
      .carry    (carry16[i])
    );
  end

  for (genvar i = 0; i < shift_pkg::vlen / shift_pkg::word_w; i++) begin : g_lane32
    shift_lane #(.width(shift_pkg::word_w)) i_shift_lane (
      .shift_op (ctrl.shift_op),
      .vxrm     (ctrl.vxrm),
      .operand  (vs2_data.w[i]),
      .amount   (ctrl.amounts.a32.a[i]),
      .shifted  (shifted32[i]),
      .rounded  (rounded32[i]),
      .carry    (carry32[i])
    );
  end

  // single-width result, rounded only for scaling shifts
  always_comb begin
    case (ctrl.eew)
      shift_pkg::eew8:  wide_data.b = ctrl.scaling ? rounded8 : shifted8;
      shift_pkg::eew16: wide_data.h = ctrl.scaling ? rounded16 : shifted16;
      shift_pkg::eew32: wide_data.w = ctrl.scaling ? rounded32 : shifted32;
      default:          wide_data   = '0;
    endcase
  end

endmodule

`default_nettype wire

/* verification/tb_rvv_alu_shift.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rvv_alu_shift;

  // about 140 uops at one per cycle plus reset and some margin
  localparam int max_cycles = 400;

  logic         clk;
  logic         arst_n;
  logic         uop_valid;
  logic [5:0]   funct6;
  logic [2:0]   funct3;
  logic [1:0]   vxrm;
  logic [127:0] vs1_data;
  logic         vs1_valid;
  logic [127:0] vs2_data;
  logic         vs2_valid;
  logic [1:0]   vs2_eew;
  logic [31:0]  rs1_data;
  logic         rs1_valid;
  logic [2:0]   uop_index;
  logic         result_valid;
  logic [127:0] result_data;
  logic         vxsat;

  logic [31:0]  rng_state = 32'd18;
  int           cycles = 0;

  rvv_alu_shift i_rvv_alu_shift (
    .clk          (clk),
    .arst_n       (arst_n),
    .uop_valid    (uop_valid),
    .funct6       (funct6),
    .funct3       (funct3),
    .vxrm         (vxrm),
    .vs1_data     (vs1_data),
    .vs1_valid    (vs1_valid),
    .vs2_data     (vs2_data),
    .vs2_valid    (vs2_valid),
    .vs2_eew      (vs2_eew),
    .rs1_data     (rs1_data),
    .rs1_valid    (rs1_valid),
    .uop_index    (uop_index),
    .result_valid (result_valid),
    .result_data  (result_data),
    .vxsat        (vxsat)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cycles <= cycles + 1;

  initial begin
    wait (cycles >= max_cycles);
    $display("Some tests failed");
    $fatal(1, "run timed out after %0d cycles", max_cycles);
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [127:0] rand_vec();
    logic [127:0] v;
    for (int i = 0; i < 4; i++)
      v[i*32 +: 32] = next_rand();
    return v;
  endfunction

  function automatic logic [5:0] op_for_index(input int k);
    case (k)
      0:       return shift_pkg::vsll;
      1:       return shift_pkg::vsrl;
      2:       return shift_pkg::vsra;
      3:       return shift_pkg::vssrl;
      4:       return shift_pkg::vssra;
      5:       return shift_pkg::vnsrl;
      6:       return shift_pkg::vnsra;
      7:       return shift_pkg::vnclipu;
      default: return shift_pkg::vnclip;
    endcase
  endfunction

  function automatic logic [2:0] form_for_index(input int k);
    case (k)
      0:       return shift_pkg::opivv;
      1:       return shift_pkg::opivx;
      default: return shift_pkg::opivi;
    endcase
  endfunction

  // one source element at full precision before clamping
  function automatic longint lane_value(input logic [1:0] kind, input logic [1:0] mode,
                                        input bit do_round, input int w,
                                        input logic [31:0] x, input int a);
    longint v;
    longint q;
    bit     half_bit;
    bit     below;
    bit     sticky;
    bit     incr;
    v = longint'(x);
    if (kind == shift_pkg::sra && x[w-1])
      v = v - (longint'(1) << w);
    if (kind == shift_pkg::sll)
      return (v << a) & ((longint'(1) << w) - 1);
    q    = v >>> a;
    incr = 1'b0;
    if (do_round && a > 0) begin
      half_bit = v[a-1];
      below    = (v & ((longint'(1) << (a - 1)) - 1)) != 0;
      sticky   = (v & ((longint'(1) << a) - 1)) != 0;
      case (mode)
        shift_pkg::rnu: incr = half_bit;
        shift_pkg::rne: incr = half_bit && (below || q[0]);
        shift_pkg::rod: incr = !q[0] && sticky;
        default:        incr = 1'b0;
      endcase
    end
    return q + longint'(incr);
  endfunction

  task automatic model_uop(input logic [5:0] f6, input logic [2:0] f3, input logic [1:0] mode,
                           input logic [1:0] eew, input logic [127:0] v1,
                           input logic [127:0] v2, input logic [31:0] s1, input logic upper,
                           output logic [127:0] exp_data, output logic exp_sat);
    logic [1:0]   kind;
    bit           scaling;
    bit           narrowing;
    bit           clipping;
    bit           clip_signed;
    int           w;
    int           a;
    longint       val;
    longint       lo;
    longint       hi;
    logic [127:0] tmp;
    logic [127:0] narrow;
    logic [31:0]  x;
    kind        = shift_pkg::srl;
    scaling     = 1'b0;
    narrowing   = 1'b0;
    clipping    = 1'b0;
    clip_signed = 1'b0;
    if (f6 == shift_pkg::vsll)
      kind = shift_pkg::sll;
    if (f6 == shift_pkg::vsra || f6 == shift_pkg::vssra || f6 == shift_pkg::vnsra ||
        f6 == shift_pkg::vnclip)
      kind = shift_pkg::sra;
    scaling     = (f6 == shift_pkg::vssrl) || (f6 == shift_pkg::vssra);
    clipping    = (f6 == shift_pkg::vnclipu) || (f6 == shift_pkg::vnclip);
    clip_signed = (f6 == shift_pkg::vnclip);
    narrowing   = clipping || (f6 == shift_pkg::vnsrl) || (f6 == shift_pkg::vnsra);
    w        = 8 << eew;
    exp_data = '0;
    exp_sat  = 1'b0;
    narrow   = '0;
    for (int i = 0; i < 128 / w; i++) begin
      tmp = v2 >> (i * w);
      x   = tmp[31:0] & 32'((64'd1 << w) - 1);
      tmp = (f3 == shift_pkg::opivv) ? (v1 >> (i * w)) : 128'(s1);
      a   = int'(tmp[4:0]) & (w - 1);
      val = lane_value(kind, mode, scaling || clipping, w, x, a);
      if (!narrowing) begin
        exp_data = exp_data | (128'(val & ((longint'(1) << w) - 1)) << (i * w));
      end else begin
        if (clipping) begin
          hi = clip_signed ? (longint'(1) << (w / 2 - 1)) - 1 : (longint'(1) << (w / 2)) - 1;
          lo = clip_signed ? -(longint'(1) << (w / 2 - 1)) : 0;
          if (val > hi || val < lo)
            exp_sat = 1'b1;
          val = (val > hi) ? hi : ((val < lo) ? lo : val);
        end
        narrow = narrow | (128'(val & ((longint'(1) << (w / 2)) - 1)) << (i * w / 2));
      end
    end
    if (narrowing)
      exp_data = upper ? (narrow << 64) : narrow;
  endtask

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      $display("Some tests failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic run_uop(input logic [5:0] f6, input logic [2:0] f3, input logic [1:0] mode,
                         input logic [1:0] eew, input logic [127:0] v1, input logic [127:0] v2,
                         input logic [31:0] s1, input logic [2:0] idx);
    logic [127:0] exp_data;
    logic         exp_sat;
    model_uop(f6, f3, mode, eew, v1, v2, s1, idx[0], exp_data, exp_sat);
    uop_valid = 1'b1;
    funct6    = f6;
    funct3    = f3;
    vxrm      = mode;
    vs2_eew   = eew;
    vs1_data  = v1;
    vs2_data  = v2;
    rs1_data  = s1;
    uop_index = idx;
    @(posedge clk);
    #1;
    check_value("result_valid", result_valid, 1'b1);
    check_value("result_data", result_data, exp_data);
    check_value("vxsat", vxsat, exp_sat);
    uop_valid = 1'b0;
  endtask

  // immediate form carries a 5-bit value on rs1
  task automatic run_random(input logic [5:0] f6, input logic [1:0] eew, input logic [1:0] mode,
                            input logic [2:0] idx, input logic [2:0] f3);
    logic [31:0] s1;
    s1 = (f3 == shift_pkg::opivi) ? (next_rand() & 32'h1f) : next_rand();
    run_uop(f6, f3, mode, eew, rand_vec(), rand_vec(), s1, idx);
  endtask

  task automatic run_illegal(input logic [5:0] f6, input logic [2:0] f3, input logic [1:0] eew,
                             input logic v1_ok, input logic s1_ok);
    uop_valid = 1'b1;
    funct6    = f6;
    funct3    = f3;
    vs2_eew   = eew;
    vs1_valid = v1_ok;
    rs1_valid = s1_ok;
    vs1_data  = rand_vec();
    vs2_data  = rand_vec();
    rs1_data  = next_rand();
    @(posedge clk);
    #1;
    check_value("result_valid", result_valid, 1'b0);
    check_value("vxsat", vxsat, 1'b0);
    uop_valid = 1'b0;
    vs1_valid = 1'b1;
    rs1_valid = 1'b1;
  endtask

  // legal uop held during reset while the outputs stay cleared
  task automatic test_reset();
    uop_valid = 1'b1;
    funct6    = shift_pkg::vsll;
    funct3    = shift_pkg::opivx;
    vs2_data  = rand_vec();
    rs1_data  = 32'd3;
    repeat (4) begin
      @(posedge clk);
      #1;
      check_value("result_valid", result_valid, 1'b0);
      check_value("vxsat", vxsat, 1'b0);
      check_value("result_data", result_data, '0);
    end
    uop_valid = 1'b0;
    arst_n    = 1'b1;
    @(posedge clk);
    #1;
    check_value("result_valid", result_valid, 1'b0);
    check_value("vxsat", vxsat, 1'b0);
  endtask

  task automatic test_illegal();
    run_illegal(6'b000000, shift_pkg::opivv, shift_pkg::eew8, 1'b1, 1'b1);
    run_illegal(shift_pkg::vsll, shift_pkg::opivv, shift_pkg::eew16, 1'b0, 1'b1);
    run_illegal(shift_pkg::vsra, shift_pkg::opivx, shift_pkg::eew32, 1'b1, 1'b0);
    run_illegal(shift_pkg::vssrl, shift_pkg::opivi, shift_pkg::eew8, 1'b1, 1'b0);
    run_illegal(shift_pkg::vnsrl, shift_pkg::opivx, shift_pkg::eew8, 1'b1, 1'b1);
    run_illegal(shift_pkg::vnclip, shift_pkg::opivv, shift_pkg::eew8, 1'b1, 1'b1);
    // random clip data saturates some lane, so vxsat must still be gated
    run_illegal(shift_pkg::vnclip, shift_pkg::opivv, shift_pkg::eew16, 1'b0, 1'b1);
  endtask

  task automatic test_single_width();
    for (int k = 0; k < 3; k++)
      for (int e = 0; e < 3; e++)
        for (int f = 0; f < 3; f++)
          run_random(op_for_index(k), 2'(e), 2'(next_rand()), 3'(next_rand()),
                     form_for_index(f));
  endtask

  task automatic test_scaling();
    for (int k = 3; k < 5; k++)
      for (int m = 0; m < 4; m++)
        for (int e = 0; e < 3; e++)
          run_random(op_for_index(k), 2'(e), 2'(m), 3'(next_rand()),
                     form_for_index(int'(next_rand() % 3)));
    // ties with odd and even kept bits where rne and rod disagree
    for (int m = 0; m < 4; m++) begin
      run_uop(shift_pkg::vssrl, shift_pkg::opivv, 2'(m), shift_pkg::eew8, {16{8'h02}},
              128'h0302_0706_0e0a_0506_fafe_0302_0706_0e0a, 32'd0, 3'd0);
      run_uop(shift_pkg::vssra, shift_pkg::opivx, 2'(m), shift_pkg::eew16, '0,
              128'h0018_0008_fff8_0019_ffe8_0007_7ff8_8008, 32'd4, 3'd0);
    end
  endtask

  task automatic test_narrowing();
    for (int k = 5; k < 7; k++)
      for (int e = 1; e < 3; e++)
        for (int u = 0; u < 2; u++)
          run_random(op_for_index(k), 2'(e), 2'(next_rand()), 3'(u),
                     form_for_index(int'(next_rand() % 3)));
  endtask

  task automatic test_clip();
    run_uop(shift_pkg::vnclipu, shift_pkg::opivx, shift_pkg::rnu, shift_pkg::eew16, '0,
            128'hffff_00ff_0100_0080_0000_7fff_00fe_0001, 32'd0, 3'd0);
    run_uop(shift_pkg::vnclip, shift_pkg::opivx, shift_pkg::rnu, shift_pkg::eew16, '0,
            128'h7fff_8000_007f_ff80_ff7f_0080_0000_ffff, 32'd0, 3'd1);
    // rounding alone pushes 0x7f80 past the signed maximum
    run_uop(shift_pkg::vnclip, shift_pkg::opivx, shift_pkg::rnu, shift_pkg::eew16, '0,
            128'h7fff_7f7f_80ff_8080_0000_00ff_ff00_7f80, 32'd8, 3'd0);
    run_uop(shift_pkg::vnclipu, shift_pkg::opivx, shift_pkg::rdn, shift_pkg::eew16, '0,
            rand_vec(), 32'd8, 3'd1);
    run_uop(shift_pkg::vnclip, shift_pkg::opivx, shift_pkg::rdn, shift_pkg::eew32, '0,
            rand_vec(), 32'd16, 3'd0);
    run_uop(shift_pkg::vnclipu, shift_pkg::opivx, shift_pkg::rod, shift_pkg::eew32, '0,
            128'hffff_ffff_0000_ffff_0001_0000_1234_5678, 32'd0, 3'd0);
    run_uop(shift_pkg::vnclip, shift_pkg::opivx, shift_pkg::rne, shift_pkg::eew32, '0,
            128'h7fff_ffff_8000_0000_0000_7fff_ffff_8000, 32'd0, 3'd1);
    for (int k = 7; k < 9; k++)
      for (int e = 1; e < 3; e++)
        for (int m = 0; m < 4; m++)
          run_random(op_for_index(k), 2'(e), 2'(m), 3'(next_rand()),
                     form_for_index(int'(next_rand() % 3)));
  endtask

  task automatic test_back_to_back();
    int         k;
    logic [1:0] e;
    for (int n = 0; n < 40; n++) begin
      k = int'(next_rand() % 9);
      e = 2'(next_rand() % 3);
      // narrowing has no 8-bit source
      if (k >= 5 && e == shift_pkg::eew8)
        e = shift_pkg::eew16;
      run_random(op_for_index(k), e, 2'(next_rand()), 3'(next_rand()),
                 form_for_index(int'(next_rand() % 3)));
    end
  endtask

  initial begin
    arst_n    = 1'b0;
    uop_valid = 1'b0;
    funct6    = '0;
    funct3    = '0;
    vxrm      = '0;
    vs1_data  = '0;
    vs1_valid = 1'b1;
    vs2_data  = '0;
    vs2_valid = 1'b1;
    vs2_eew   = shift_pkg::eew8;
    rs1_data  = '0;
    rs1_valid = 1'b1;
    uop_index = '0;
    test_reset();
    test_illegal();
    test_single_width();
    test_scaling();
    test_narrowing();
    test_clip();
    test_back_to_back();
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/rvv_alu_shift.sv */
`timescale 1ns/1ps
`default_nettype none

module rvv_alu_shift (
  input  wire                                clk,
  input  wire                                arst_n,
  input  wire                                uop_valid,
  input  wire  [5:0]                         funct6,
  input  wire  [2:0]                         funct3,
  input  wire  [1:0]                         vxrm,
  input  wire  [shift_pkg::vlen-1:0]         vs1_data,
  input  wire                                vs1_valid,
  input  wire  [shift_pkg::vlen-1:0]         vs2_data,
  input  wire                                vs2_valid,
  input  wire  [1:0]                         vs2_eew,
  input  wire  [shift_pkg::xlen-1:0]         rs1_data,
  input  wire                                rs1_valid,
  input  wire  [shift_pkg::uop_index_w-1:0]  uop_index,
  output logic                               result_valid,
  output logic [shift_pkg::vlen-1:0]         result_data,
  output logic                               vxsat
);

  localparam int n16 = shift_pkg::vlen / shift_pkg::hword_w;
  localparam int n32 = shift_pkg::vlen / shift_pkg::word_w;

  shift_pkg::vreg_u                        wide_data;
  shift_pkg::vreg_u                        narrow_data;
  logic                                    narrow_sat;
  logic [n16-1:0][shift_pkg::hword_w-1:0]  shifted16;
  logic [n16-1:0][shift_pkg::hword_w-1:0]  rounded16;
  logic [n16-1:0]                          carry16;
  logic [n32-1:0][shift_pkg::word_w-1:0]   shifted32;
  logic [n32-1:0][shift_pkg::word_w-1:0]   rounded32;
  logic [n32-1:0]                          carry32;

  shift_ctrl_if ctrl ();

  shift_decode i_shift_decode (
    .uop_valid (uop_valid),
    .funct6    (funct6),
    .funct3    (funct3),
    .vxrm      (vxrm),
    .vs1_data  (vs1_data),
    .vs1_valid (vs1_valid),
    .vs2_valid (vs2_valid),
    .vs2_eew   (vs2_eew),
    .rs1_data  (rs1_data),
    .rs1_valid (rs1_valid),
    .uop_index (uop_index),
    .ctrl      (ctrl.decoder)
  );

  shift_lane_bank i_shift_lane_bank (
    .vs2_data  (vs2_data),
    .ctrl      (ctrl.datapath),
    .wide_data (wide_data),
    .shifted16 (shifted16),
    .rounded16 (rounded16),
    .carry16   (carry16),
    .shifted32 (shifted32),
    .rounded32 (rounded32),
    .carry32   (carry32)
  );

  shift_narrow i_shift_narrow (
    .shifted16   (shifted16),
    .rounded16   (rounded16),
    .carry16     (carry16),
    .shifted32   (shifted32),
    .rounded32   (rounded32),
    .carry32     (carry32),
    .ctrl        (ctrl.datapath),
    .narrow_data (narrow_data),
    .sat         (narrow_sat)
  );

  // single output stage
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result_valid <= 1'b0;
      result_data  <= '0;
      vxsat        <= 1'b0;
    end else begin
      result_valid <= ctrl.op_valid;
      result_data  <= ctrl.narrowing ? narrow_data : wide_data;
      vxsat        <= ctrl.op_valid && narrow_sat;
    end
  end

  a_sat_from_clip: assert property (@(posedge clk) disable iff (!arst_n)
    vxsat |-> $past(ctrl.clipping))
    else $error("vxsat raised for a uop that was not a clip");

  a_narrow_upper_zero: assert property (@(posedge clk) disable iff (!arst_n)
    result_valid && $past(ctrl.narrowing && !ctrl.upper_half)
    |-> result_data[shift_pkg::vlen-1:shift_pkg::vlen/2] == '0)
    else $error("narrowing result leaked into upper half");

endmodule

`default_nettype wire

/* verilog/shift_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module shift_decode (
  input  wire                                   uop_valid,
  input  wire  [5:0]                            funct6,
  input  wire  [2:0]                            funct3,
  input  wire  [1:0]                            vxrm,
  input  wire  shift_pkg::vreg_u                vs1_data,
  input  wire                                   vs1_valid,
  input  wire                                   vs2_valid,
  input  wire  [1:0]                            vs2_eew,
  input  wire  [shift_pkg::xlen-1:0]            rs1_data,
  input  wire                                   rs1_valid,
  input  wire  [shift_pkg::uop_index_w-1:0]     uop_index,
  shift_ctrl_if.decoder                         ctrl
);

  logic known;
  logic vec_form;
  logic scalar_form;
  logic operand_ok;

  always_comb begin
    known            = 1'b1;
    ctrl.shift_op    = shift_pkg::sll;
    ctrl.scaling     = 1'b0;
    ctrl.narrowing   = 1'b0;
    ctrl.clipping    = 1'b0;
    ctrl.clip_signed = 1'b0;
    case (funct6)
      shift_pkg::vsll: ctrl.shift_op = shift_pkg::sll;
      shift_pkg::vsrl: ctrl.shift_op = shift_pkg::srl;
      shift_pkg::vsra: ctrl.shift_op = shift_pkg::sra;
      shift_pkg::vssrl, shift_pkg::vssra: begin
        ctrl.shift_op = (funct6 == shift_pkg::vssra) ? shift_pkg::sra : shift_pkg::srl;
        ctrl.scaling  = 1'b1;
      end
      shift_pkg::vnsrl, shift_pkg::vnsra: begin
        ctrl.shift_op  = (funct6 == shift_pkg::vnsra) ? shift_pkg::sra : shift_pkg::srl;
        ctrl.narrowing = 1'b1;
      end
      shift_pkg::vnclipu, shift_pkg::vnclip: begin
        ctrl.clip_signed = (funct6 == shift_pkg::vnclip);
        ctrl.shift_op    = ctrl.clip_signed ? shift_pkg::sra : shift_pkg::srl;
        ctrl.narrowing   = 1'b1;
        ctrl.clipping    = 1'b1;
      end
      default: known = 1'b0;
    endcase
  end

  // vs1 for vector-vector and rs1 for both scalar and immediate
  assign vec_form    = (funct3 == shift_pkg::opivv);
  assign scalar_form = (funct3 == shift_pkg::opivx) || (funct3 == shift_pkg::opivi);
  assign operand_ok  = vs2_valid && (vec_form ? vs1_valid : (scalar_form && rs1_valid));

  assign ctrl.op_valid   = uop_valid && known && operand_ok &&
                           !(ctrl.narrowing && (vs2_eew == shift_pkg::eew8));
  assign ctrl.eew        = vs2_eew;
  assign ctrl.vxrm       = vxrm;
  assign ctrl.upper_half = uop_index[0];

  // only the low log2(sew) bits of the amount matter
  always_comb begin
    ctrl.amounts = '0;
    case (vs2_eew)
      shift_pkg::eew8:
        for (int i = 0; i < shift_pkg::vlenb; i++)
          ctrl.amounts.a8[i] = vec_form ? vs1_data.b[i][shift_pkg::amt8_w-1:0]
                                        : rs1_data[shift_pkg::amt8_w-1:0];
      shift_pkg::eew16:
        for (int i = 0; i < shift_pkg::vlen / shift_pkg::hword_w; i++)
          ctrl.amounts.a16.a[i] = vec_form ? vs1_data.h[i][shift_pkg::amt16_w-1:0]
                                           : rs1_data[shift_pkg::amt16_w-1:0];
      shift_pkg::eew32:
        for (int i = 0; i < shift_pkg::vlen / shift_pkg::word_w; i++)
          ctrl.amounts.a32.a[i] = vec_form ? vs1_data.w[i][shift_pkg::amt32_w-1:0]
                                           : rs1_data[shift_pkg::amt32_w-1:0];
      default: ctrl.amounts = '0;
    endcase
  end

  a_no_rsvd_eew: assert final (!(uop_valid && vs2_eew == shift_pkg::eew_rsvd))
    else $error("valid uop with reserved eew");

endmodule

`default_nettype wire

/* verilog/shift_narrow.sv */
`timescale 1ns/1ps
`default_nettype none

module shift_narrow (
  input  wire  [shift_pkg::vlen/shift_pkg::hword_w-1:0][shift_pkg::hword_w-1:0] shifted16,
  input  wire  [shift_pkg::vlen/shift_pkg::hword_w-1:0][shift_pkg::hword_w-1:0] rounded16,
  input  wire  [shift_pkg::vlen/shift_pkg::hword_w-1:0]                         carry16,
  input  wire  [shift_pkg::vlen/shift_pkg::word_w-1:0][shift_pkg::word_w-1:0]   shifted32,
  input  wire  [shift_pkg::vlen/shift_pkg::word_w-1:0][shift_pkg::word_w-1:0]   rounded32,
  input  wire  [shift_pkg::vlen/shift_pkg::word_w-1:0]                          carry32,
  shift_ctrl_if.datapath                                                        ctrl,
  output shift_pkg::vreg_u                                                      narrow_data,
  output logic                                                                  sat
);

  localparam int n16 = shift_pkg::vlen / shift_pkg::hword_w;
  localparam int n32 = shift_pkg::vlen / shift_pkg::word_w;
  localparam int hb  = shift_pkg::byte_w;
  localparam int hh  = shift_pkg::hword_w;

  logic [shift_pkg::vlen/2-1:0] half;
  logic [n16-1:0]               lane_sat;
  logic [hh:0]                  clipped;

  // value is the rounded element with its carry, sign extended to 33 bits
  // returns {saturated, clamped result in the low hw bits}
  function automatic logic [16:0] clip_lane(input logic [32:0] value, input int hw,
                                            input logic signed_clip);
    logic [32:0] hi;
    logic [15:0] mask;
    logic        over;
    logic        under;
    logic [15:0] res;
    mask = 16'((17'd1 << hw) - 17'd1);
    if (signed_clip) begin
      hi    = $signed(value) >>> (hw - 1);
      over  = !value[32] && (hi != '0);
      under = value[32] && (hi != '1);
    end else begin
      hi    = value >> hw;
      over  = (hi != '0);
      under = 1'b0;
    end
    res = value[15:0] & mask;
    if (over)
      res = signed_clip ? (mask >> 1) : mask;
    else if (under)
      res = ~(mask >> 1) & mask;
    return {over | under, res};
  endfunction

  always_comb begin
    half     = '0;
    lane_sat = '0;
    clipped  = '0;
    case (ctrl.eew)
      shift_pkg::eew16:
        for (int j = 0; j < n16; j++) begin
          if (ctrl.clipping) begin
            clipped = clip_lane({{16{ctrl.clip_signed & carry16[j]}}, carry16[j], rounded16[j]},
                                hb, ctrl.clip_signed);
            lane_sat[j]      = clipped[hh];
            half[j*hb +: hb] = clipped[hb-1:0];
          end else begin
            half[j*hb +: hb] = shifted16[j][hb-1:0];
          end
        end
      shift_pkg::eew32:
        for (int j = 0; j < n32; j++) begin
          if (ctrl.clipping) begin
            clipped          = clip_lane({carry32[j], rounded32[j]}, hh, ctrl.clip_signed);
            lane_sat[j]      = clipped[hh];
            half[j*hh +: hh] = clipped[hh-1:0];
          end else begin
            half[j*hh +: hh] = shifted32[j][hh-1:0];
          end
        end
      default: half = '0;
    endcase
  end

  // other half of the destination stays zero
  assign narrow_data = ctrl.upper_half ? {half, {(shift_pkg::vlen/2){1'b0}}}
                                       : {{(shift_pkg::vlen/2){1'b0}}, half};
  assign sat = |lane_sat;

endmodule

`default_nettype wire
